//--- centipede_map_pkg.sv
`default_nettype none

// cpu address map of the operator control and i/o port pages
package centipede_map_pkg;

   // 14-bit cpu address bus
   localparam int addr_width = 14;

   // page is address bits 13..10
   localparam int page_width = 4;

   // index of one bit of the out latch, address bits 2..0
   localparam int latch_idx_width = 3;

   // page numbers still decoded here
   // option switch read, sw1 or sw2 by half select
   localparam logic [page_width-1:0] page_switch = 4'd2;
   // player input and joystick read ports
   localparam logic [page_width-1:0] page_input = 4'd3;
   // coin counter and led latch write
   localparam logic [page_width-1:0] page_out_latch = 4'd7;
   // trackball counter clear write
   localparam logic [page_width-1:0] page_steer_clr = 4'd9;

   // one address word seen two ways
   typedef union packed {
      // read view, used on the switch and input pages
      struct packed {
         logic [page_width-1:0]              page;
         logic [addr_width-page_width-3:0]   unused;
         // 0 picks in0, 1 picks in1
         logic                               port_sel;
         // 0 picks the low word, 1 the high word
         logic                               half_sel;
      } port;
      // write view, used on the out latch page
      struct packed {
         logic [page_width-1:0]                          page;
         logic [addr_width-page_width-latch_idx_width-1:0] unused;
         logic [latch_idx_width-1:0]                     bit_idx;
      } latch;
   } io_addr_u;

endpackage

`default_nettype wire

//--- centipede_ctrl_pkg.sv
`default_nettype none

// bit layout of the control words on the i/o side
package centipede_ctrl_pkg;

   // cpu data bus and read word width
   localparam int data_width = 8;

   // trackball up/down counter width
   localparam int tb_count_width = 4;

   // data bus bit copied into the addressed latch bit
   localparam int latch_data_bit = 7;
   localparam int latch_sel_width = $clog2(data_width);

   // out latch bit positions
   // coin drives also index the 3-bit coin drive vector
   localparam int latch_coin_l = 0;
   localparam int latch_coin_c = 1;
   localparam int latch_coin_r = 2;
   localparam int latch_led_first = 3;
   localparam int latch_led_last = 6;
   localparam int latch_flip = 7;

   // player input bits, as wired from the cabinet
   localparam int player_width = 10;
   localparam int pin_coin_r = 9;
   localparam int pin_coin_c = 8;
   localparam int pin_coin_l = 7;
   localparam int pin_self_test = 6;
   localparam int pin_cocktail = 5;
   localparam int pin_slam = 4;
   localparam int pin_start1 = 3;
   localparam int pin_start2 = 2;
   localparam int pin_fire2 = 1;
   localparam int pin_fire1 = 0;

   // trackball bits, player 1 odd and player 2 even
   localparam int trakball_width = 8;
   localparam int tb_p1_h_dir = 7;
   localparam int tb_p2_h_dir = 6;
   localparam int tb_p1_h_clk = 5;
   localparam int tb_p2_h_clk = 4;
   localparam int tb_p1_v_dir = 3;
   localparam int tb_p2_v_dir = 2;
   localparam int tb_p1_v_clk = 1;
   localparam int tb_p2_v_clk = 0;

endpackage

`default_nettype wire

//--- trackball_axis.sv
`timescale 1ns/100ps
`default_nettype none

// one mini-trackball axis
// the raw clock and direction come from the cabinet and are async to s_6mhz
module trackball_axis
   import centipede_ctrl_pkg::*;
(
   input  wire                       s_6mhz,
   input  wire                       reset,
   input  wire                       tb_clk_i,
   input  wire                       tb_dir_i,
   // steering clear, one cycle
   input  wire                       clear_i,
   output logic [tb_count_width-1:0] count_o,
   output logic                      dir_o
);

   // two-flop synchronizers, bit 1 is the safe one
   logic [1:0] clk_sync;
   logic [1:0] dir_sync;
   // synced clock one cycle back, for the edge detect
   logic       clk_last;
   logic       clk_rise;

   always_ff @(posedge s_6mhz or posedge reset)
   begin
      if (reset)
      begin
         clk_sync <= '0;
         dir_sync <= '0;
         clk_last <= 1'b0;
      end
      else
      begin
         clk_sync <= {clk_sync[0], tb_clk_i};
         dir_sync <= {dir_sync[0], tb_dir_i};
         clk_last <= clk_sync[1];
      end
   end

   // one cycle per trackball clock rising edge
   assign clk_rise = clk_sync[1] & ~clk_last;

   // counter steps by the direction latched at the previous pulse
   // dir flop loads on the same pulse, like the original clocked latch
   always_ff @(posedge s_6mhz or posedge reset)
   begin
      if (reset)
      begin
         count_o <= '0;
         dir_o <= 1'b0;
      end
      else
      begin
         // clear only zeroes the count, dir keeps its value
         if (clear_i)
            count_o <= '0;
         else if (clk_rise)
            count_o <= dir_o ? count_o + 1'b1 : count_o - 1'b1;
         if (clk_rise)
            dir_o <= dir_sync[1];
      end
   end

endmodule

`default_nettype wire

//--- player_input_sampler.sv
`timescale 1ns/100ps
`default_nettype none

// input side, builds the four read words of the input page
module player_input_sampler
   import centipede_ctrl_pkg::*;
(
   input  wire                     s_6mhz,
   input  wire                     reset,
   input  wire  [player_width-1:0] playerinput_i,
   input  wire  [trakball_width-1:0] trakball_i,
   input  wire  [data_width-1:0]   joystick_i,
   input  wire                     vblank_i,
   // cocktail flip from the out latch, also picks the player
   input  wire                     flip_i,
   // coin counter drives, indexed by latch_coin_* positions
   input  wire  [2:0]              coin_drive_i,
   input  wire                     steer_clr_i,
   output logic [data_width-1:0]   in0_lo_o,
   output logic [data_width-1:0]   in0_hi_o,
   output logic [data_width-1:0]   in1_lo_o,
   output logic [data_width-1:0]   in1_hi_o
);

   // trackball lines of the selected player
   logic                      h_dir_in;
   logic                      h_clk_in;
   logic                      v_dir_in;
   logic                      v_clk_in;
   // axis results
   logic [tb_count_width-1:0] h_count;
   logic [tb_count_width-1:0] v_count;
   logic                      h_dir;
   logic                      v_dir;
   // coin lines after the drive force
   logic                      coin_r;
   logic                      coin_c;
   logic                      coin_l;

   // flip set means player 1 sits at the controls
   assign h_dir_in = flip_i ? trakball_i[tb_p1_h_dir] : trakball_i[tb_p2_h_dir];
   assign h_clk_in = flip_i ? trakball_i[tb_p1_h_clk] : trakball_i[tb_p2_h_clk];
   assign v_dir_in = flip_i ? trakball_i[tb_p1_v_dir] : trakball_i[tb_p2_v_dir];
   assign v_clk_in = flip_i ? trakball_i[tb_p1_v_clk] : trakball_i[tb_p2_v_clk];

   // horizontal axis, read back on in0
   trackball_axis u_axis_h (
      .s_6mhz   (s_6mhz),
      .reset    (reset),
      .tb_clk_i (h_clk_in),
      .tb_dir_i (h_dir_in),
      .clear_i  (steer_clr_i),
      .count_o  (h_count),
      .dir_o    (h_dir)
   );

   // vertical axis, read back on in1
   trackball_axis u_axis_v (
      .s_6mhz   (s_6mhz),
      .reset    (reset),
      .tb_clk_i (v_clk_in),
      .tb_dir_i (v_dir_in),
      .clear_i  (steer_clr_i),
      .count_o  (v_count),
      .dir_o    (v_dir)
   );

   // a driven coin counter reads back as an inserted coin
   assign coin_r = playerinput_i[pin_coin_r] | coin_drive_i[latch_coin_r];
   assign coin_c = playerinput_i[pin_coin_c] | coin_drive_i[latch_coin_c];
   assign coin_l = playerinput_i[pin_coin_l] | coin_drive_i[latch_coin_l];

   assign in0_lo_o = {h_dir, vblank_i, playerinput_i[pin_self_test],
                      playerinput_i[pin_cocktail], h_count};

   // note the fire and start order differs from the input pins
   assign in0_hi_o = {coin_r, coin_c, coin_l, playerinput_i[pin_slam],
                      playerinput_i[pin_fire2], playerinput_i[pin_fire1],
                      playerinput_i[pin_start1], playerinput_i[pin_start2]};

   assign in1_lo_o = {v_dir, 3'b000, v_count};

   // joystick byte goes straight through
   assign in1_hi_o = joystick_i;

endmodule

`default_nettype wire

//--- io_decoder.sv
`timescale 1ns/100ps
`default_nettype none

// page decode, delayed write strobes and the read data mux
module io_decoder
   import centipede_map_pkg::*;
   import centipede_ctrl_pkg::*;
(
   input  wire                        s_6mhz,
   input  wire                        reset,
   input  wire  io_addr_u             cpu_ab_i,
   // write level, one cycle per write
   input  wire                        cpu_wr_i,
   input  wire  [data_width-1:0]      cpu_db_i,
   input  wire  [data_width-1:0]      in0_lo_i,
   input  wire  [data_width-1:0]      in0_hi_i,
   input  wire  [data_width-1:0]      in1_lo_i,
   input  wire  [data_width-1:0]      in1_hi_i,
   input  wire  [data_width-1:0]      sw1_i,
   input  wire  [data_width-1:0]      sw2_i,
   output logic [data_width-1:0]      cpu_rd_data_o,
   output logic                       out_latch_we_o,
   output logic [latch_sel_width-1:0] latch_bit_sel_o,
   output logic                       latch_data_o,
   output logic                       steer_clr_o
);

   // page hits for this cycle
   logic hit_out_latch;
   logic hit_steer_clr;

   assign hit_out_latch = cpu_ab_i.latch.page == page_out_latch;
   assign hit_steer_clr = cpu_ab_i.port.page == page_steer_clr;

   // strobes are one cycle late, like the write2 delay on the board
   always_ff @(posedge s_6mhz or posedge reset)
   begin
      if (reset)
      begin
         out_latch_we_o <= 1'b0;
         steer_clr_o <= 1'b0;
      end
      else
      begin
         out_latch_we_o <= cpu_wr_i & hit_out_latch;
         steer_clr_o <= cpu_wr_i & hit_steer_clr;
      end
   end

   // bit index and data travel with the delayed strobe
   // only ever used under out_latch_we_o
   always_ff @(posedge s_6mhz)
   begin
      if (cpu_wr_i)
      begin
         latch_bit_sel_o <= cpu_ab_i.latch.bit_idx;
         latch_data_o <= cpu_db_i[latch_data_bit];
      end
   end

   // read side, purely combinational
   // unmapped and write-only pages read as 0
   always_comb
   begin
      cpu_rd_data_o = '0;
      case (cpu_ab_i.port.page)
         page_switch:
         begin
            cpu_rd_data_o = cpu_ab_i.port.half_sel ? sw2_i : sw1_i;
         end
         page_input:
         begin
            // port 0 player inputs, port 1 joystick and vertical axis
            if (cpu_ab_i.port.port_sel)
               cpu_rd_data_o = cpu_ab_i.port.half_sel ? in1_hi_i : in1_lo_i;
            else
               cpu_rd_data_o = cpu_ab_i.port.half_sel ? in0_hi_i : in0_lo_i;
         end
         default:
         begin
            cpu_rd_data_o = '0;
         end
      endcase
   end

endmodule

`default_nettype wire

//--- coin_counter_latch.sv
`timescale 1ns/100ps
`default_nettype none

// 8-bit addressable output latch, coin counters, leds and flip
module coin_counter_latch
   import centipede_ctrl_pkg::*;
(
   input  wire                        s_6mhz,
   input  wire                        reset,
   // delayed write strobe from the decoder
   input  wire                        we_i,
   input  wire  [latch_sel_width-1:0] bit_sel_i,
   input  wire                        data_i,
   output logic [4:1]                 led_o,
   output logic                       flip_o,
   // indexed by latch_coin_* positions
   output logic [2:0]                 coin_drive_o
);

   // one flop per output line
   logic [data_width-1:0] cc_latch;

   // only the addressed bit changes, the rest hold
   always_ff @(posedge s_6mhz or posedge reset)
   begin
      if (reset)
         cc_latch <= '0;
      else if (we_i)
         cc_latch[bit_sel_i] <= data_i;
   end

   // fan out by bit position
   assign led_o = cc_latch[latch_led_last:latch_led_first];
   assign flip_o = cc_latch[latch_flip];

   // coin bits sit at the bottom of the latch in the same order
   assign coin_drive_o[latch_coin_l] = cc_latch[latch_coin_l];
   assign coin_drive_o[latch_coin_c] = cc_latch[latch_coin_c];
   assign coin_drive_o[latch_coin_r] = cc_latch[latch_coin_r];

endmodule

`default_nettype wire

//--- centipede_io.sv
`timescale 1ns/100ps
`default_nettype none

// operator control and i/o port block of the board
module centipede_io
   import centipede_map_pkg::*;
   import centipede_ctrl_pkg::*;
(
   input  wire                       s_6mhz,
   input  wire                       reset,
   // cpu side
   input  wire  io_addr_u            cpu_ab_i,
   input  wire                       cpu_wr_i,
   input  wire  [data_width-1:0]     cpu_db_i,
   output logic [data_width-1:0]     cpu_rd_data_o,
   // cabinet side
   input  wire  [player_width-1:0]   playerinput_i,
   input  wire  [trakball_width-1:0] trakball_i,
   input  wire  [data_width-1:0]     joystick_i,
   input  wire  [data_width-1:0]     sw1_i,
   input  wire  [data_width-1:0]     sw2_i,
   input  wire                       vblank_i,
   output logic [4:1]                led_o,
   output logic                      flip_o
);

   // read words, sampler to decoder
   logic [data_width-1:0]      in0_lo;
   logic [data_width-1:0]      in0_hi;
   logic [data_width-1:0]      in1_lo;
   logic [data_width-1:0]      in1_hi;
   // delayed writes, decoder to latch and sampler
   logic                       out_latch_we;
   logic [latch_sel_width-1:0] latch_bit_sel;
   logic                       latch_data;
   logic                       steer_clr;
   // coin drives back into the input words
   logic [2:0]                 coin_drive;

   player_input_sampler u_player_input_sampler (
      .s_6mhz        (s_6mhz),
      .reset         (reset),
      .playerinput_i (playerinput_i),
      .trakball_i    (trakball_i),
      .joystick_i    (joystick_i),
      .vblank_i      (vblank_i),
      .flip_i        (flip_o),
      .coin_drive_i  (coin_drive),
      .steer_clr_i   (steer_clr),
      .in0_lo_o      (in0_lo),
      .in0_hi_o      (in0_hi),
      .in1_lo_o      (in1_lo),
      .in1_hi_o      (in1_hi)
   );

   io_decoder u_io_decoder (
      .s_6mhz          (s_6mhz),
      .reset           (reset),
      .cpu_ab_i        (cpu_ab_i),
      .cpu_wr_i        (cpu_wr_i),
      .cpu_db_i        (cpu_db_i),
      .in0_lo_i        (in0_lo),
      .in0_hi_i        (in0_hi),
      .in1_lo_i        (in1_lo),
      .in1_hi_i        (in1_hi),
      .sw1_i           (sw1_i),
      .sw2_i           (sw2_i),
      .cpu_rd_data_o   (cpu_rd_data_o),
      .out_latch_we_o  (out_latch_we),
      .latch_bit_sel_o (latch_bit_sel),
      .latch_data_o    (latch_data),
      .steer_clr_o     (steer_clr)
   );

   // flip leaves the block and also steers the trackball mux
   coin_counter_latch u_coin_counter_latch (
      .s_6mhz       (s_6mhz),
      .reset        (reset),
      .we_i         (out_latch_we),
      .bit_sel_i    (latch_bit_sel),
      .data_i       (latch_data),
      .led_o        (led_o),
      .flip_o       (flip_o),
      .coin_drive_o (coin_drive)
   );

endmodule

`default_nettype wire

//--- centipede_io_checker.sv
`timescale 1ns/100ps
`default_nettype none

// concurrent checks bound onto the top level
module centipede_io_checker
   import centipede_map_pkg::*;
   import centipede_ctrl_pkg::*;
(
   input wire                  s_6mhz,
   input wire                  reset,
   input wire io_addr_u        cpu_ab_i,
   input wire                  cpu_wr_i,
   input wire [data_width-1:0] cpu_rd_data_o,
   input wire [4:1]            led_o,
   input wire                  flip_o
);

   // number of failed assertions
   int assert_fail_count = 0;

   // write-only and unused pages read back 0
   assert property (@(posedge s_6mhz) disable iff (reset)
      (cpu_ab_i.port.page != page_switch && cpu_ab_i.port.page != page_input)
      |-> cpu_rd_data_o == '0)
   else
   begin
      $error("read data not 0 on an unmapped page");
      assert_fail_count++;
   end

   // outputs quiet while in reset
   assert property (@(posedge s_6mhz) reset |-> (led_o == '0 && !flip_o))
   else
   begin
      $error("leds or flip active during reset");
      assert_fail_count++;
   end

   // delayed write, nothing moves at the first edge after the write
   assert property (@(posedge s_6mhz) disable iff (reset)
      (cpu_wr_i && cpu_ab_i.latch.page == page_out_latch) |=> $stable({led_o, flip_o}))
   else
   begin
      $error("out latch changed one edge too early");
      assert_fail_count++;
   end

endmodule

`default_nettype wire

//--- centipede_io_tests.svh
`ifndef CENTIPEDE_IO_TESTS_SVH
`define CENTIPEDE_IO_TESTS_SVH

// option switches, port select is a don't care on this page
task automatic test_switches();
   logic [data_width-1:0] data;
   @(negedge s_6mhz);
   sw1 = 8'($urandom);
   sw2 = 8'($urandom);
   read_bus(port_addr(page_switch, 1'b0, 1'b0), data);
   check_value("cpu_rd_data_o (sw1)", data, sw1);
   read_bus(port_addr(page_switch, 1'b0, 1'b1), data);
   check_value("cpu_rd_data_o (sw2)", data, sw2);
   read_bus(port_addr(page_switch, 1'b1, 1'b0), data);
   check_value("cpu_rd_data_o (sw1, port 1)", data, sw1);
endtask

// random buttons, joystick and vblank through the input page
task automatic test_player_input();
   repeat (4)
   begin
      @(negedge s_6mhz);
      playerinput = 10'($urandom);
      joystick = 8'($urandom);
      vblank = 1'($urandom);
      check_read_words();
   end
endtask

// data bit 7 goes to the latch, the low bits are noise
task automatic write_latch(input int idx, input logic value);
   write_bus(latch_addr(3'(idx)), {value, 7'($urandom)});
   latch_model[idx] = value;
endtask

task automatic test_coin_latch();
   // coin inputs low so only the drives raise the coin bits
   @(negedge s_6mhz);
   playerinput[pin_coin_r] = 1'b0;
   playerinput[pin_coin_c] = 1'b0;
   playerinput[pin_coin_l] = 1'b0;
   // set bits one by one, earlier ones must hold
   for (int idx = 0; idx < data_width; idx++)
   begin
      write_latch(idx, 1'b1);
      wait_cycles(2);
      check_latch_outputs();
   end
   for (int idx = data_width - 1; idx >= 0; idx--)
   begin
      write_latch(idx, 1'b0);
      wait_cycles(2);
      check_latch_outputs();
   end
endtask

// one trackball pulse, dir set a cycle ahead of the clock
task automatic pulse_axis(input logic player1, input logic vertical, input logic dir);
   int clk_bit;
   int dir_bit;
   if (vertical)
   begin
      clk_bit = player1 ? tb_p1_v_clk : tb_p2_v_clk;
      dir_bit = player1 ? tb_p1_v_dir : tb_p2_v_dir;
   end
   else
   begin
      clk_bit = player1 ? tb_p1_h_clk : tb_p2_h_clk;
      dir_bit = player1 ? tb_p1_h_dir : tb_p2_h_dir;
   end
   @(negedge s_6mhz);
   trakball[dir_bit] = dir;
   @(negedge s_6mhz);
   trakball[clk_bit] = 1'b1;
   wait_cycles(2);
   trakball[clk_bit] = 1'b0;
   wait_cycles(2);
   // counts by the previous dir, then takes the new one
   if (player1 == latch_model[latch_flip])
   begin
      if (vertical)
      begin
         v_cnt_model = v_dir_model ? v_cnt_model + 1'b1 : v_cnt_model - 1'b1;
         v_dir_model = dir;
      end
      else
      begin
         h_cnt_model = h_dir_model ? h_cnt_model + 1'b1 : h_cnt_model - 1'b1;
         h_dir_model = dir;
      end
   end
endtask

task automatic test_trackball();
   int n;
   // flip clear, player 2 owns the counters
   n = 3 + $urandom % 8;
   repeat (n) pulse_axis(1'b0, 1'b0, 1'b1);
   n = 3 + $urandom % 8;
   repeat (n) pulse_axis(1'b0, 1'b1, 1'b0);
   wait_cycles(8);
   check_read_words();
   // player 1 lines are ignored here
   repeat (4) pulse_axis(1'b1, 1'b0, 1'b0);
   repeat (4) pulse_axis(1'b1, 1'b1, 1'b1);
   wait_cycles(8);
   check_read_words();
   write_latch(latch_flip, 1'b1);
   wait_cycles(2);
   n = 3 + $urandom % 8;
   repeat (n) pulse_axis(1'b1, 1'b0, 1'b0);
   repeat (n) pulse_axis(1'b1, 1'b1, 1'b1);
   wait_cycles(8);
   check_read_words();
endtask

// clear zeroes both counts, dir flops keep their state
task automatic test_steer_clear();
   // both counts off zero so the clear shows
   while (h_cnt_model == '0)
      pulse_axis(latch_model[latch_flip], 1'b0, h_dir_model);
   while (v_cnt_model == '0)
      pulse_axis(latch_model[latch_flip], 1'b1, v_dir_model);
   wait_cycles(8);
   check_read_words();
   write_bus(port_addr(page_steer_clr, 1'b0, 1'b0), 8'($urandom));
   h_cnt_model = '0;
   v_cnt_model = '0;
   wait_cycles(2);
   check_read_words();
   write_latch(latch_flip, 1'b0);
   wait_cycles(2);
   check_latch_outputs();
endtask

task automatic test_unmapped();
   logic [data_width-1:0] data;
   for (int page = 0; page < 16; page++)
   begin
      if (page != page_switch && page != page_input)
      begin
         read_bus(port_addr(4'(page), 1'b0, 1'b0), data);
         check_value("cpu_rd_data_o (unmapped)", data, 0);
         read_bus(port_addr(4'(page), 1'b1, 1'b1), data);
         check_value("cpu_rd_data_o (unmapped)", data, 0);
      end
   end
   // writes to dead pages, all latch index bits set
   for (int page = 0; page < 16; page++)
   begin
      if (page != page_switch && page != page_input && page != page_out_latch
          && page != page_steer_clr)
         write_bus(port_addr(4'(page), 1'b1, 1'b1) | 14'h7, 8'hff);
   end
   wait_cycles(2);
   check_latch_outputs();
   check_read_words();
endtask

`endif

//--- tb_centipede_io.sv
`timescale 1ns/100ps
`default_nettype none

// testbench for the operator control and i/o port block
module tb_centipede_io
   import centipede_map_pkg::*;
   import centipede_ctrl_pkg::*;
();

   localparam int clk_period = 40;
   // rough length of all tests, the watchdog allows twice that
   localparam int est_test_cycles = 1500;

   logic                      s_6mhz = 1'b0;
   logic                      reset;
   io_addr_u                  cpu_ab;
   logic                      cpu_wr;
   logic [data_width-1:0]     cpu_db;
   logic [data_width-1:0]     cpu_rd_data;
   logic [player_width-1:0]   playerinput;
   logic [trakball_width-1:0] trakball;
   logic [data_width-1:0]     joystick;
   logic [data_width-1:0]     sw1;
   logic [data_width-1:0]     sw2;
   logic                      vblank;
   logic [4:1]                led;
   logic                      flip;

   // expected state, kept by the tests
   logic [data_width-1:0]     latch_model;
   logic [tb_count_width-1:0] h_cnt_model;
   logic [tb_count_width-1:0] v_cnt_model;
   logic                      h_dir_model;
   logic                      v_dir_model;

   always #(clk_period / 2) s_6mhz = ~s_6mhz;

   centipede_io u_centipede_io (
      .s_6mhz        (s_6mhz),
      .reset         (reset),
      .cpu_ab_i      (cpu_ab),
      .cpu_wr_i      (cpu_wr),
      .cpu_db_i      (cpu_db),
      .cpu_rd_data_o (cpu_rd_data),
      .playerinput_i (playerinput),
      .trakball_i    (trakball),
      .joystick_i    (joystick),
      .sw1_i         (sw1),
      .sw2_i         (sw2),
      .vblank_i      (vblank),
      .led_o         (led),
      .flip_o        (flip)
   );

   bind centipede_io centipede_io_checker u_centipede_io_checker (.*);

   // hard stop if a test hangs
   initial
   begin
      #(2 * est_test_cycles * clk_period);
      $display("timeout: the tests did not finish in time");
      $display("test failed");
      $fatal(1, "watchdog expired");
   end

   task automatic check_value(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
      if (actual !== expected)
      begin
         $display("mismatch %s: actual 0x%0h expected 0x%0h", name, actual, expected);
         $display("test failed");
         $fatal(1, "stopped at first error");
      end
   endtask

   task automatic wait_cycles(input int n);
      repeat (n) @(negedge s_6mhz);
   endtask

   // write level held for exactly one rising edge
   task automatic write_bus(input io_addr_u addr, input logic [data_width-1:0] data);
      @(negedge s_6mhz);
      cpu_ab = addr;
      cpu_db = data;
      cpu_wr = 1'b1;
      @(negedge s_6mhz);
      cpu_wr = 1'b0;
   endtask

   // read data is combinational, sampled a quarter period after the address
   task automatic read_bus(input io_addr_u addr, output logic [data_width-1:0] data);
      @(negedge s_6mhz);
      cpu_ab = addr;
      cpu_wr = 1'b0;
      #(clk_period / 4);
      data = cpu_rd_data;
   endtask

   function automatic io_addr_u port_addr(input logic [page_width-1:0] page,
                                          input logic port_sel, input logic half_sel);
      io_addr_u addr;
      addr = '0;
      addr.port.page = page;
      addr.port.port_sel = port_sel;
      addr.port.half_sel = half_sel;
      return addr;
   endfunction

   function automatic io_addr_u latch_addr(input logic [2:0] idx);
      io_addr_u addr;
      addr = '0;
      addr.latch.page = page_out_latch;
      addr.latch.bit_idx = idx;
      return addr;
   endfunction

   // horizontal dir, vblank, self-test, cocktail, horizontal count
   function automatic logic [7:0] expect_in0_lo();
      return {h_dir_model, vblank, playerinput[pin_self_test],
              playerinput[pin_cocktail], h_cnt_model};
   endfunction

   // coins forced by their drives, then slam, fire2, fire1, start1, start2
   function automatic logic [7:0] expect_in0_hi();
      return {playerinput[pin_coin_r] | latch_model[latch_coin_r],
              playerinput[pin_coin_c] | latch_model[latch_coin_c],
              playerinput[pin_coin_l] | latch_model[latch_coin_l],
              playerinput[pin_slam], playerinput[pin_fire2], playerinput[pin_fire1],
              playerinput[pin_start1], playerinput[pin_start2]};
   endfunction

   function automatic logic [7:0] expect_in1_lo();
      return {v_dir_model, 3'b000, v_cnt_model};
   endfunction

   task automatic check_read_words();
      logic [data_width-1:0] data;
      read_bus(port_addr(page_input, 1'b0, 1'b0), data);
      check_value("cpu_rd_data_o (in0_lo)", data, expect_in0_lo());
      read_bus(port_addr(page_input, 1'b0, 1'b1), data);
      check_value("cpu_rd_data_o (in0_hi)", data, expect_in0_hi());
      read_bus(port_addr(page_input, 1'b1, 1'b0), data);
      check_value("cpu_rd_data_o (in1_lo)", data, expect_in1_lo());
      read_bus(port_addr(page_input, 1'b1, 1'b1), data);
      check_value("cpu_rd_data_o (in1_hi)", data, joystick);
   endtask

   task automatic check_latch_outputs();
      logic [data_width-1:0] data;
      check_value("led_o", led, latch_model[latch_led_last:latch_led_first]);
      check_value("flip_o", flip, latch_model[latch_flip]);
      read_bus(port_addr(page_input, 1'b0, 1'b1), data);
      check_value("cpu_rd_data_o (in0_hi coins)", data, expect_in0_hi());
   endtask

`include "centipede_io_tests.svh"

   initial
   begin
      void'($urandom(32'h45cc0eb1));
      reset = 1'b1;
      cpu_ab = '0;
      cpu_wr = 1'b0;
      cpu_db = '0;
      playerinput = '0;
      trakball = '0;
      joystick = '0;
      sw1 = '0;
      sw2 = '0;
      vblank = 1'b0;
      latch_model = '0;
      h_cnt_model = '0;
      v_cnt_model = '0;
      h_dir_model = 1'b0;
      v_dir_model = 1'b0;
      repeat (2) @(negedge s_6mhz);
      reset = 1'b0;

      test_switches();
      test_player_input();
      test_coin_latch();
      test_trackball();
      test_steer_clear();
      test_unmapped();
      wait_cycles(4);

      if (u_centipede_io.u_centipede_io_checker.assert_fail_count == 0)
      begin
         $display("test passed");
         $finish;
      end
      else
      begin
         $display("assertion failures: %0d",
                  u_centipede_io.u_centipede_io_checker.assert_fail_count);
         $display("test failed");
         $fatal(1, "run ended with errors");
      end
   end

endmodule

`default_nettype wire

//--- centipede_io.f
+incdir+.
centipede_map_pkg.sv
centipede_ctrl_pkg.sv
trackball_axis.sv
player_input_sampler.sv
io_decoder.sv
coin_counter_latch.sv
centipede_io.sv
centipede_io_checker.sv
tb_centipede_io.sv

//--- Bender.yml
package:
  name: centipede_io

sources:
  - files:
      - centipede_map_pkg.sv
      - centipede_ctrl_pkg.sv
      - trackball_axis.sv
      - player_input_sampler.sv
      - io_decoder.sv
      - coin_counter_latch.sv
      - centipede_io.sv
  - target: test
    include_dirs:
      - .
    files:
      - centipede_io_checker.sv
      - tb_centipede_io.sv
